// ==== fp_ss.f ====
verilog/fp_ss_pkg.sv
verilog/fp_ss_decoder.sv
verilog/fp16_lane.sv
verilog/fp_ss_writeback.sv
verilog/fp_ss.sv
sim/fp_ss_assertions.sv
sim/fp_ss_tb.sv

// ==== Bender.yml ====
package:
  name: fp_ss

sources:
  - verilog/fp_ss_pkg.sv
  - verilog/fp_ss_decoder.sv
  - verilog/fp16_lane.sv
  - verilog/fp_ss_writeback.sv
  - verilog/fp_ss.sv
  - target: simulation
    files:
      - sim/fp_ss_assertions.sv
      - sim/fp_ss_tb.sv

// ==== sim/fp_ss_tb.sv ====
/*
  Directed and random testbench for the FP16 subsystem.
  Responses are checked in order against a behavioral model of the lane rules.
*/

module fp_ss_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fp_ss_pkg::*;

  localparam int unsigned RAND_SEED    = 32'he477_733c;
  localparam int unsigned NUM_RANDOM   = 2000;
  // Requests sent by the directed tests
  localparam int unsigned NUM_DIRECTED = 1 + 3 * 8 + 5 * 8 + 4 * 8 + 2 * 4;
  localparam int unsigned MAX_CYCLES   = 20 * (NUM_RANDOM + NUM_DIRECTED);

  typedef struct packed {
    logic [31:0]     cycle;
    logic [ID_W-1:0] id;
    logic            error;
    logic [FLEN-1:0] data;
  } resp_t;

  logic            clk_i;
  logic            reset_i;
  logic            req_valid_i;
  logic            req_ready_o;
  fp_op_e          req_op_i;
  logic [ID_W-1:0] req_id_i;
  logic [FLEN-1:0] req_arga_i;
  logic [FLEN-1:0] req_argb_i;
  logic            resp_valid_o;
  logic            resp_ready_i;
  logic [ID_W-1:0] resp_id_o;
  logic [FLEN-1:0] resp_data_o;
  logic            resp_error_o;
  logic            issue_o;

  resp_t           exp_q[$];
  resp_t           head;
  logic [FLEN:0]   model;
  bit              stall_en;
  int unsigned     cycle_cnt;
  int unsigned     id_cnt;
  int unsigned     accept_cnt;
  int unsigned     issue_cnt;
  int unsigned     check_cnt;
  int unsigned     err_cnt;
  int unsigned     fail_total;

  fp_ss fp_ss_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic bit is_nan(lane_t h);
    return (h[14:10] == 5'h1f) && (h[9:0] != 10'h000);
  endfunction

  function automatic bit is_zero(lane_t h);
    return h[14:0] == 15'h0000;
  endfunction

  // Signed ordering key with -0 just below +0
  function automatic int order_key(lane_t h);
    if (h[15]) begin
      return -int'(h[14:0]) - 1;
    end
    return int'(h[14:0]);
  endfunction

  function automatic lane_t lane_value(fp_op_e op, lane_t a, lane_t b);
    case (op)
      OP_FSGNJ, OP_VFSGNJ:   return {b[15], a[14:0]};
      OP_FSGNJN, OP_VFSGNJN: return {~b[15], a[14:0]};
      OP_FSGNJX, OP_VFSGNJX: return {a[15] ^ b[15], a[14:0]};
      OP_FMIN, OP_VFMIN, OP_FMAX, OP_VFMAX: begin
        if (is_nan(a) && is_nan(b)) return 16'h7e00;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        if (op == OP_FMIN || op == OP_VFMIN) begin
          return (order_key(a) < order_key(b)) ? a : b;
        end
        return (order_key(a) > order_key(b)) ? a : b;
      end
      default: return a;
    endcase
  endfunction

  function automatic logic compare_true(fp_op_e op, lane_t a, lane_t b);
    bit eq;
    bit lt;
    if (is_nan(a) || is_nan(b)) begin
      return 1'b0;
    end
    eq = (a == b) || (is_zero(a) && is_zero(b));
    lt = !eq && (order_key(a) < order_key(b));
    case (op)
      OP_FEQ:  return eq;
      OP_FLT:  return lt;
      default: return lt || eq;
    endcase
  endfunction

  // Returns {error, data}
  function automatic logic [FLEN:0] expect_resp(fp_op_e op, logic [FLEN-1:0] a,
                                                logic [FLEN-1:0] b);
    lane_t lo;
    lane_t hi;
    lo = lane_value(op, a[15:0], b[15:0]);
    hi = lane_value(op, a[31:16], b[31:16]);
    case (op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX: return {1'b0, 16'hffff, lo};
      OP_FEQ, OP_FLT, OP_FLE: return {1'b0, 31'd0, compare_true(op, a[15:0], b[15:0])};
      OP_FMV_X: return {1'b0, {16{a[15]}}, a[15:0]};
      OP_VFSGNJ, OP_VFSGNJN, OP_VFSGNJX, OP_VFMIN, OP_VFMAX: return {1'b0, hi, lo};
      default: return {1'b1, 32'd0};
    endcase
  endfunction

  // --------------------
  // Stimulus
  // --------------------
  function automatic lane_t rand_half();
    logic [31:0] r;
    r = $urandom;
    case (r[2:0])
      3'd0:    return {r[3], 5'h1f, 1'b1, r[12:4]};
      3'd1:    return {r[3], 5'h1f, 1'b0, r[12:4] | 9'h001};  // signalling NaN
      3'd2:    return {r[3], 15'h0000};
      3'd3:    return {r[3], 5'h1f, 10'h000};
      default: return r[31:16];
    endcase
  endfunction

  task automatic random_pair(output logic [FLEN-1:0] a, output logic [FLEN-1:0] b);
    a = {rand_half(), rand_half()};
    case ($urandom % 4)
      0:       b = a;
      1:       b = a ^ 32'h8000_8000;
      default: b = {rand_half(), rand_half()};
    endcase
  endtask

  task automatic drive_ready();
    if (stall_en) begin
      resp_ready_i <= ($urandom % 3) != 0;
    end else begin
      resp_ready_i <= 1'b1;
    end
  endtask

  task automatic idle_cycle();
    req_valid_i <= 1'b0;
    @(posedge clk_i);
    drive_ready();
  endtask

  task automatic send_req(input fp_op_e op, input logic [FLEN-1:0] a,
                          input logic [FLEN-1:0] b);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_id_i    <= ID_W'(id_cnt);
    req_arga_i  <= a;
    req_argb_i  <= b;
    id_cnt++;
    do begin
      @(posedge clk_i);
      drive_ready();
    end while (!req_ready_o);
  endtask

  task automatic drain();
    req_valid_i <= 1'b0;
    do begin
      @(posedge clk_i);
      drive_ready();
    end while (exp_q.size() != 0);
  endtask

  task automatic run_test(input string name, input int first_op, input int last_op,
                          input int reps, input bit stall);
    int unsigned     start_err;
    int unsigned     start_cnt;
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    start_err = err_cnt;
    start_cnt = accept_cnt;
    stall_en  = stall;
    for (int r = 0; r < reps; r++) begin
      for (int op = first_op; op <= last_op; op++) begin
        random_pair(a, b);
        if (stall && ($urandom % 4) == 0) begin
          idle_cycle();
        end
        send_req(fp_op_e'(4'(stall ? $urandom % 16 : op)), a, b);
      end
    end
    drain();
    $display("%-16s %0d requests, %0d errors", name, accept_cnt - start_cnt,
             err_cnt - start_err);
  endtask

  // --------------------
  // Scoreboard
  // --------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (resp_valid_o && resp_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Error at %0t: response tag %0h arrived with nothing outstanding",
                   $time, resp_id_o);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_value("resp_id_o", resp_id_o, head.id);
          check_value("resp_error_o", resp_error_o, head.error);
          check_value("resp_data_o", resp_data_o, head.data);
          // Without stalls every response takes exactly two cycles
          if (!stall_en) begin
            check_value("response latency", cycle_cnt - head.cycle, 2);
          end
        end
      end
      if (req_valid_i && req_ready_o) begin
        model = expect_resp(req_op_i, req_arga_i, req_argb_i);
        exp_q.push_back({cycle_cnt, req_id_i, model});
        accept_cnt++;
      end
      if (issue_o) begin
        issue_cnt++;
      end
    end
    cycle_cnt++;
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
    end
    $display("Error: run did not end within %0d cycles, %0d responses outstanding",
             MAX_CYCLES, exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(RAND_SEED));
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = OP_FSGNJ;
    req_id_i     = '0;
    req_arga_i   = '0;
    req_argb_i   = '0;
    resp_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    run_test("single latency", OP_FMV_X, OP_FMV_X, 1, 1'b0);
    run_test("sign inject", OP_FSGNJ, OP_FSGNJX, 8, 1'b0);
    run_test("vector rules", OP_VFSGNJ, OP_VFMAX, 8, 1'b0);
    run_test("compare move", OP_FEQ, OP_FMV_X, 8, 1'b0);
    run_test("illegal opcode", 14, 15, 4, 1'b0);
    run_test("random traffic", 0, 0, NUM_RANDOM, 1'b1);

    check_value("issue_o pulse count", issue_cnt, accept_cnt);
    fail_total = err_cnt + fp_ss_i.protocol_checks.fail_cnt;
    $display("Totals: %0d requests, %0d checks, %0d errors", accept_cnt, check_cnt,
             fail_total);
    if (fail_total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim/fp_ss_assertions.sv ====
/*
  Protocol checks bound into the top level.
  The failure count is read by the testbench at the end of the run.
*/

module fp_ss_assertions (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic                         req_valid_i,
  input logic                         req_ready_o,
  input logic                         resp_valid_o,
  input logic                         resp_ready_i,
  input logic [fp_ss_pkg::ID_W-1:0]   resp_id_o,
  input logic [fp_ss_pkg::FLEN-1:0]   resp_data_o,
  input logic                         resp_error_o,
  input logic                         issue_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;
  logic        accept;

  assign accept = req_valid_i & req_ready_o;

  // Stalled response holds its fields
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_id_o) &&
                                      $stable(resp_data_o) && $stable(resp_error_o))
  else begin
    $error("response fields changed while stalled");
    fail_cnt++;
  end

  assert property (@(posedge clk_i) reset_i |=> !resp_valid_o && !issue_o)
  else begin
    $error("response valid or issue strobe high after reset");
    fail_cnt++;
  end

  // Issue strobe mirrors the accept handshake one cycle later
  assert property (@(posedge clk_i) disable iff (reset_i) accept |=> issue_o)
  else begin
    $error("issue strobe missing after an accepted request");
    fail_cnt++;
  end

  assert property (@(posedge clk_i) disable iff (reset_i) !accept |=> !issue_o)
  else begin
    $error("issue strobe without an accepted request");
    fail_cnt++;
  end

endmodule

bind fp_ss fp_ss_assertions protocol_checks (.*);

// ==== verilog/fp_ss.sv ====
/*
  FP16 subsystem on a valid/ready accelerator port.
  Two cycles from accept to response, one request per cycle.
*/

module fp_ss (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Accelerator request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  fp_ss_pkg::fp_op_e             req_op_i,
  input  logic [fp_ss_pkg::ID_W-1:0]    req_id_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    req_arga_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    req_argb_i,
  // Accelerator response
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output logic [fp_ss_pkg::ID_W-1:0]    resp_id_o,
  output logic [fp_ss_pkg::FLEN-1:0]    resp_data_o,
  output logic                          resp_error_o,
  // Core event strobe
  output logic                          issue_o
);

  import fp_ss_pkg::*;

  logic                  issue_valid;
  lane_func_e            lane_func;
  res_kind_e             res_kind;
  logic [ID_W-1:0]       req_id;
  logic                  issue_error;
  logic [FLEN-1:0]       op_a;
  logic [FLEN-1:0]       op_b;
  logic                  wb_ready;
  lane_t [NUM_LANES-1:0] lane_result;
  logic [NUM_LANES-1:0]  lane_flag;

  fp_ss_decoder i_decoder (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .req_valid_i   ( req_valid_i ),
    .req_op_i      ( req_op_i    ),
    .req_id_i      ( req_id_i    ),
    .req_arga_i    ( req_arga_i  ),
    .req_argb_i    ( req_argb_i  ),
    .req_ready_o   ( req_ready_o ),
    .wb_ready_i    ( wb_ready    ),
    .issue_valid_o ( issue_valid ),
    .func_o        ( lane_func   ),
    .kind_o        ( res_kind    ),
    .id_o          ( req_id      ),
    .a_o           ( op_a        ),
    .b_o           ( op_b        ),
    .error_o       ( issue_error ),
    .issue_o       ( issue_o     )
  );

  // One lane per 16-bit half of the operands
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    fp16_lane i_lane (
      .func_i   ( lane_func                  ),
      .a_i      ( op_a[i*LANE_W +: LANE_W]   ),
      .b_i      ( op_b[i*LANE_W +: LANE_W]   ),
      .result_o ( lane_result[i]             ),
      .flag_o   ( lane_flag[i]               )
    );
  end

  fp_ss_writeback i_writeback (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .valid_i       ( issue_valid  ),
    .kind_i        ( res_kind     ),
    .id_i          ( req_id       ),
    .error_i       ( issue_error  ),
    .lane_result_i ( lane_result  ),
    .lane_flag_i   ( lane_flag    ),
    .ready_o       ( wb_ready     ),
    .resp_ready_i  ( resp_ready_i ),
    .resp_valid_o  ( resp_valid_o ),
    .resp_id_o     ( resp_id_o    ),
    .resp_data_o   ( resp_data_o  ),
    .resp_error_o  ( resp_error_o )
  );

endmodule

// ==== verilog/fp_ss_writeback.sv ====
/*
  Response formatting and one-entry output register.
  Error responses always carry zero data.
*/

module fp_ss_writeback (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  // From the issue register and lanes
  input  logic                                           valid_i,
  input  fp_ss_pkg::res_kind_e                           kind_i,
  input  logic [fp_ss_pkg::ID_W-1:0]                     id_i,
  input  logic                                           error_i,
  input  fp_ss_pkg::lane_t [fp_ss_pkg::NUM_LANES-1:0]    lane_result_i,
  input  logic [fp_ss_pkg::NUM_LANES-1:0]                lane_flag_i,
  output logic                                           ready_o,
  // Response to the core
  input  logic                                           resp_ready_i,
  output logic                                           resp_valid_o,
  output logic [fp_ss_pkg::ID_W-1:0]                     resp_id_o,
  output logic [fp_ss_pkg::FLEN-1:0]                     resp_data_o,
  output logic                                           resp_error_o
);

  import fp_ss_pkg::*;

  logic [FLEN-1:0] wb_data;
  logic            valid_q;

  // --------------------
  // Result merge
  // --------------------
  always_comb begin
    case (kind_i)
      RES_VEC:  wb_data = lane_result_i;
      RES_BOX:  wb_data = {{(FLEN-LANE_W){1'b1}}, lane_result_i[0]};
      RES_BIT:  wb_data = {{(FLEN-1){1'b0}}, lane_flag_i[0]};
      RES_SEXT: wb_data = {{(FLEN-LANE_W){lane_result_i[0][LANE_W-1]}}, lane_result_i[0]};
      default:  wb_data = '0;
    endcase
    if (error_i) begin
      wb_data = '0;
    end
  end

  // --------------------
  // Output register
  // --------------------
  assign ready_o = ~valid_q | resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload holds while the core stalls
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      resp_id_o    <= id_i;
      resp_data_o  <= wb_data;
      resp_error_o <= error_i;
    end
  end

  assign resp_valid_o = valid_q;

endmodule

// ==== verilog/fp16_lane.sv ====
/*
  Combinational FP16 lane for sign injection, min/max and compares.
  Min/max follow the RISC-V rules, with canonical NaN 16'h7e00.
*/

module fp16_lane (
  input  fp_ss_pkg::lane_func_e func_i,
  input  fp_ss_pkg::lane_t      a_i,
  input  fp_ss_pkg::lane_t      b_i,
  output fp_ss_pkg::lane_t      result_o,
  output logic                  flag_o
);

  import fp_ss_pkg::*;

  localparam lane_t CANON_NAN = 16'h7e00;

  logic a_sign;
  logic b_sign;
  logic a_nan;
  logic b_nan;
  logic any_nan;
  logic both_zero;
  logic lt_total;
  logic is_eq;
  logic is_lt;
  lane_t min_val;
  lane_t max_val;

  // --------------------
  // Classification
  // --------------------
  assign a_sign    = a_i[LANE_W-1];
  assign b_sign    = b_i[LANE_W-1];
  assign a_nan     = (&a_i[14:10]) & (|a_i[9:0]);
  assign b_nan     = (&b_i[14:10]) & (|b_i[9:0]);
  assign any_nan   = a_nan | b_nan;
  assign both_zero = (a_i[LANE_W-2:0] == '0) & (b_i[LANE_W-2:0] == '0);

  // Ordering where -0 sits below +0
  always_comb begin
    if (a_sign != b_sign) begin
      lt_total = a_sign;
    end else if (a_sign) begin
      lt_total = b_i[LANE_W-2:0] < a_i[LANE_W-2:0];
    end else begin
      lt_total = a_i[LANE_W-2:0] < b_i[LANE_W-2:0];
    end
  end

  assign is_eq = (a_i == b_i) | both_zero;
  assign is_lt = lt_total & ~both_zero;

  // --------------------
  // Min and max
  // --------------------
  always_comb begin
    if (a_nan & b_nan) begin
      min_val = CANON_NAN;
      max_val = CANON_NAN;
    end else if (a_nan) begin
      min_val = b_i;
      max_val = b_i;
    end else if (b_nan) begin
      min_val = a_i;
      max_val = a_i;
    end else begin
      min_val = lt_total ? a_i : b_i;
      max_val = lt_total ? b_i : a_i;
    end
  end

  // Result select
  always_comb begin
    result_o = a_i;
    flag_o   = 1'b0;
    case (func_i)
      F_SGNJ:  result_o = {b_sign, a_i[LANE_W-2:0]};
      F_SGNJN: result_o = {~b_sign, a_i[LANE_W-2:0]};
      F_SGNJX: result_o = {a_sign ^ b_sign, a_i[LANE_W-2:0]};
      F_MIN:   result_o = min_val;
      F_MAX:   result_o = max_val;
      F_EQ:    flag_o   = ~any_nan & is_eq;
      F_LT:    flag_o   = ~any_nan & is_lt;
      F_LE:    flag_o   = ~any_nan & (is_lt | is_eq);
      default: result_o = a_i;
    endcase
  end

endmodule

// ==== verilog/fp_ss_decoder.sv ====
/*
  Request decoder with a one-entry issue register.
  Scalar operands use their low half with no NaN-box check.
*/

module fp_ss_decoder (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Request from the core
  input  logic                            req_valid_i,
  input  fp_ss_pkg::fp_op_e               req_op_i,
  input  logic [fp_ss_pkg::ID_W-1:0]      req_id_i,
  input  logic [fp_ss_pkg::FLEN-1:0]      req_arga_i,
  input  logic [fp_ss_pkg::FLEN-1:0]      req_argb_i,
  output logic                            req_ready_o,
  // Issue register towards lanes and write-back
  input  logic                            wb_ready_i,
  output logic                            issue_valid_o,
  output fp_ss_pkg::lane_func_e           func_o,
  output fp_ss_pkg::res_kind_e            kind_o,
  output logic [fp_ss_pkg::ID_W-1:0]      id_o,
  output logic [fp_ss_pkg::FLEN-1:0]      a_o,
  output logic [fp_ss_pkg::FLEN-1:0]      b_o,
  output logic                            error_o,
  // Event strobe
  output logic                            issue_o
);

  import fp_ss_pkg::*;

  lane_func_e dec_func;
  res_kind_e  dec_kind;
  logic       dec_error;

  logic       valid_q;
  logic       issue_q;
  logic       accept;

  // --------------------
  // Opcode decode
  // --------------------
  always_comb begin
    dec_func  = F_PASS;
    dec_kind  = RES_BIT;
    dec_error = 1'b0;
    case (req_op_i)
      OP_FSGNJ: begin
        dec_func = F_SGNJ;
        dec_kind = RES_BOX;
      end
      OP_FSGNJN: begin
        dec_func = F_SGNJN;
        dec_kind = RES_BOX;
      end
      OP_FSGNJX: begin
        dec_func = F_SGNJX;
        dec_kind = RES_BOX;
      end
      OP_FMIN: begin
        dec_func = F_MIN;
        dec_kind = RES_BOX;
      end
      OP_FMAX: begin
        dec_func = F_MAX;
        dec_kind = RES_BOX;
      end
      OP_FEQ:  dec_func = F_EQ;
      OP_FLT:  dec_func = F_LT;
      OP_FLE:  dec_func = F_LE;
      // Raw move sign-extended in write-back
      OP_FMV_X: begin
        dec_func = F_PASS;
        dec_kind = RES_SEXT;
      end
      OP_VFSGNJ: begin
        dec_func = F_SGNJ;
        dec_kind = RES_VEC;
      end
      OP_VFSGNJN: begin
        dec_func = F_SGNJN;
        dec_kind = RES_VEC;
      end
      OP_VFSGNJX: begin
        dec_func = F_SGNJX;
        dec_kind = RES_VEC;
      end
      OP_VFMIN: begin
        dec_func = F_MIN;
        dec_kind = RES_VEC;
      end
      OP_VFMAX: begin
        dec_func = F_MAX;
        dec_kind = RES_VEC;
      end
      default: dec_error = 1'b1;
    endcase
  end

  // --------------------
  // Issue register
  // --------------------
  assign req_ready_o = ~valid_q | wb_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      issue_q <= 1'b0;
    end else begin
      if (req_ready_o) begin
        valid_q <= req_valid_i;
      end
      issue_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      func_o  <= dec_func;
      kind_o  <= dec_kind;
      error_o <= dec_error;
      id_o    <= req_id_i;
      a_o     <= req_arga_i;
      b_o     <= req_argb_i;
    end
  end

  assign issue_valid_o = valid_q;
  assign issue_o       = issue_q;

endmodule

// ==== verilog/fp_ss_pkg.sv ====
/*
  Shared widths and encodings of the FP16 subsystem.
  Operands and responses are FLEN wide and split into LANE_W lanes.
*/

package fp_ss_pkg;

  localparam int unsigned FLEN      = 32;
  localparam int unsigned LANE_W    = 16;
  localparam int unsigned NUM_LANES = FLEN / LANE_W;
  localparam int unsigned ID_W      = 5;

  typedef logic [LANE_W-1:0] lane_t;

  // Request opcodes with the last two codes left illegal
  typedef enum logic [3:0] {
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMIN,
    OP_FMAX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_FMV_X,
    OP_VFSGNJ,
    OP_VFSGNJN,
    OP_VFSGNJX,
    OP_VFMIN,
    OP_VFMAX
  } fp_op_e;

  // Function computed by each lane
  typedef enum logic [3:0] {
    F_SGNJ,
    F_SGNJN,
    F_SGNJX,
    F_MIN,
    F_MAX,
    F_EQ,
    F_LT,
    F_LE,
    F_PASS
  } lane_func_e;

  // Response formatting in write-back
  typedef enum logic [1:0] {
    RES_VEC,
    RES_BOX,
    RES_BIT,
    RES_SEXT
  } res_kind_e;

endpackage
